// File: hw/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

  // {cs, ras, cas, we} as driven on the pins
  localparam logic [3:0] cmd_inhibit      = 4'b1111;
  localparam logic [3:0] cmd_nop          = 4'b0111;
  localparam logic [3:0] cmd_active       = 4'b0011;
  localparam logic [3:0] cmd_read         = 4'b0101;
  localparam logic [3:0] cmd_write        = 4'b0100;
  localparam logic [3:0] cmd_precharge    = 4'b0010;
  localparam logic [3:0] cmd_auto_refresh = 4'b0001;
  localparam logic [3:0] cmd_load_mode    = 4'b0000;

  // timing in 8 ns cycles
  localparam int t_rcd       = 3;   // 20 ns
  localparam int cas_latency = 3;
  localparam int burst_len   = 2;   // one 32-bit word = two beats
  localparam int t_rp        = 3;
  localparam int t_rc        = 9;   // 66 ns
  localparam logic [9:0] refresh_interval = 10'd960;  // ~7.7 us
  localparam logic [4:0] init_cycles      = 5'd25;    // short power-up count

  // step numbers of an access, ACTIVE is step 0
  localparam int step_rd_first = t_rcd + cas_latency;          // first read beat sampled
  localparam int step_rd_last  = step_rd_first + burst_len - 1;
  localparam int step_acc_end  = t_rcd + burst_len + t_rp;     // bank precharged, tRC met
  localparam int step_ref_end  = t_rc - 2;                      // next cmd lands on t_rc

  // mode register: wb enabled, std op, CL3, sequential, BL2
  localparam logic [12:0] mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'b001};

  // word address split: bank | row | column word
  localparam int row_w  = 13;
  localparam int col_w  = 9;
  localparam int bank_w = 2;

  // memory-request interface widths
  localparam int mem_addr_w = 23;
  localparam int mem_data_w = 32;
  localparam int mem_be_w   = 4;

  typedef struct packed {
    logic [1:0] unused;
    logic       a10;      // auto-precharge
    logic [9:0] col;
  } sd_col_t;

  typedef struct packed {
    logic [2:0] reserved;
    logic       wb_mode;     // 0 = write burst enabled
    logic [1:0] op_mode;
    logic [2:0] cas_lat;
    logic       burst_type;  // 0 = sequential
    logic [2:0] burst_len;
  } sd_mode_t;

  // sd_addr seen as column/A10 or as mode word
  typedef union packed {
    sd_col_t  col;
    sd_mode_t mode;
  } sd_addr_u;

endpackage

`default_nettype wire

// File: hw/mem_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// one request in flight, ack is a single-cycle pulse
interface mem_req_if;

  logic                             req;
  logic                             we;     // 1 = write
  logic [sdram_pkg::mem_addr_w-1:0] addr;   // 32-bit word address
  logic [sdram_pkg::mem_data_w-1:0] wdata;
  logic [sdram_pkg::mem_be_w-1:0]   be;     // byte enables
  logic                             ack;
  logic [sdram_pkg::mem_data_w-1:0] rdata;  // valid with ack on reads

  modport requester (
    output req, we, addr, wdata, be,
    input  ack, rdata
  );

  modport server (
    input  req, we, addr, wdata, be,
    output ack, rdata
  );

  // observe only
  modport monitor (
    input req, we, addr, wdata, be, ack, rdata
  );

endinterface

`default_nettype wire

// File: hw/axil_port.sv
`timescale 1ns/1ns
`default_nettype none

module axil_port (
  input  wire         clk125_mhz,
  input  wire         rst,
  // write address / data / response
  input  wire         awvalid,
  output logic        awready,
  input  wire  [24:0] awaddr,
  input  wire         wvalid,
  output logic        wready,
  input  wire  [31:0] wdata,
  input  wire  [3:0]  wstrb,
  output logic        bvalid,
  input  wire         bready,
  output logic [1:0]  bresp,
  // read address / data
  input  wire         arvalid,
  output logic        arready,
  input  wire  [24:0] araddr,
  output logic        rvalid,
  input  wire         rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  mem_req_if.requester mem
);

  logic idle;       // no request out, no response waiting
  logic accept_rd;
  logic accept_wr;

  assign idle      = !mem.req && !bvalid && !rvalid;
  assign accept_rd = idle && arvalid;                        // read wins
  assign accept_wr = idle && !arvalid && awvalid && wvalid;  // aw and w together

  assign bresp = 2'b00;  // OKAY
  assign rresp = 2'b00;

  // --------------------------------------------------
  // handshake flags: idle -> request -> response
  always_ff @(posedge clk125_mhz) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      mem.req <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= accept_wr;  // single-cycle ready pulses
      wready  <= accept_wr;
      arready <= accept_rd;
      if (accept_rd || accept_wr) mem.req <= 1'b1;  // req up with ready

      if (mem.req && mem.ack) begin
        mem.req <= 1'b0;
        bvalid  <= mem.we;    // response the cycle after ack
        rvalid  <= !mem.we;
      end

      if (bvalid && bready) bvalid <= 1'b0;
      if (rvalid && rready) rvalid <= 1'b0;
    end
  end

  // request fields and read data
  always_ff @(posedge clk125_mhz) begin
    if (accept_rd) begin
      mem.we   <= 1'b0;
      mem.addr <= araddr[sdram_pkg::mem_addr_w+1:2];  // byte -> word address
    end else if (accept_wr) begin
      mem.we    <= 1'b1;
      mem.addr  <= awaddr[sdram_pkg::mem_addr_w+1:2];
      mem.wdata <= wdata;
      mem.be    <= wstrb;
    end
    if (mem.req && mem.ack && !mem.we) rdata <= mem.rdata;  // held till rready
  end

  // --------------------------------------------------
  // response stays put under back-pressure
  a_b_hold: assert property (@(posedge clk125_mhz) disable iff (rst)
    bvalid && !bready |=> bvalid);
  a_r_hold: assert property (@(posedge clk125_mhz) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// File: hw/sdram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_arbiter (
  input  wire          clk125_mhz,
  input  wire          rst,
  mem_req_if.server    p0,
  mem_req_if.server    p1,
  mem_req_if.requester mem
);

  logic [1:0] grant;    // one-hot, bit 0 = port 0
  logic       last_p1;  // port 1 was served last

  // grant is held for the whole request, moves on ack
  always_ff @(posedge clk125_mhz) begin
    if (rst) begin
      grant   <= 2'b00;
      last_p1 <= 1'b1;  // port 0 first
      mem.req <= 1'b0;
    end else begin
      if (grant == 2'b00) begin
        if (p0.req && (!p1.req || last_p1)) grant <= 2'b01;
        else if (p1.req) grant <= 2'b10;
      end else if (mem.ack) begin
        last_p1 <= grant[1];
        if (grant[0] && p1.req) grant <= 2'b10;       // hand over
        else if (grant[1] && p0.req) grant <= 2'b01;
        else grant <= 2'b00;
      end

      // req one cycle behind the grant, dropped on ack
      if (mem.ack) mem.req <= 1'b0;
      else mem.req <= (grant[0] && p0.req) || (grant[1] && p1.req);
    end
  end

  // fields from the granted port
  assign mem.we    = grant[1] ? p1.we    : p0.we;
  assign mem.addr  = grant[1] ? p1.addr  : p0.addr;
  assign mem.wdata = grant[1] ? p1.wdata : p0.wdata;
  assign mem.be    = grant[1] ? p1.be    : p0.be;

  // ack and data back to the owner only
  assign p0.ack   = mem.ack && grant[0];
  assign p1.ack   = mem.ack && grant[1];
  assign p0.rdata = grant[0] ? mem.rdata : '0;
  assign p1.rdata = grant[1] ? mem.rdata : '0;

  a_grant_onehot: assert property (@(posedge clk125_mhz) disable iff (rst)
    $onehot0(grant));
  a_grant_stable: assert property (@(posedge clk125_mhz) disable iff (rst)
    mem.req && !mem.ack |=> $stable(grant));

endmodule

`default_nettype wire

// File: hw/sdram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl (
  input  wire         clk125_mhz,
  input  wire         rst,
  mem_req_if.server   mem,
  inout  wire  [15:0] sd_data,
  output logic [12:0] sd_addr,
  output logic [1:0]  sd_ba,
  output logic [1:0]  sd_dqm,
  output logic        sd_cs,
  output logic        sd_ras,
  output logic        sd_cas,
  output logic        sd_we,
  output logic        sd_cke,
  output logic        sd_clk
);

  logic [$bits(sdram_pkg::init_cycles)-1:0]      init_cnt;
  logic [$bits(sdram_pkg::refresh_interval)-1:0] ref_cnt;
  logic                  init_done;
  logic                  ref_pend;    // refresh owed
  logic                  start_ref;
  logic                  start_acc;
  logic                  busy;
  logic                  is_ref;      // current slot is a refresh
  logic                  is_wr;
  logic [3:0]            step;        // cycle count since ACTIVE / REFRESH
  logic [3:0]            sd_cmd;
  sdram_pkg::sd_addr_u   addr_q;
  logic [15:0]           dout_q;
  logic                  data_oe;

  assign sd_clk = ~clk125_mhz;  // 180 deg, chip samples mid-cycle
  assign sd_cke = 1'b1;
  assign {sd_cs, sd_ras, sd_cas, sd_we} = sd_cmd;
  assign sd_addr = addr_q;
  assign sd_data = data_oe ? dout_q : 16'hzzzz;

  // --------------------------------------------------
  // power-up count and refresh timer
  assign init_done = (init_cnt == 0);

  always_ff @(posedge clk125_mhz) begin
    if (rst) init_cnt <= sdram_pkg::init_cycles;
    else if (!init_done) init_cnt <= init_cnt - 1'b1;
  end

  always_ff @(posedge clk125_mhz) begin
    if (rst) begin
      ref_cnt  <= '0;
      ref_pend <= 1'b0;
    end else begin
      if (start_ref) ref_pend <= 1'b0;
      if (ref_cnt == sdram_pkg::refresh_interval - 1'b1) begin
        ref_cnt  <= '0;
        ref_pend <= 1'b1;
      end else begin
        ref_cnt <= ref_cnt + 1'b1;
      end
    end
  end

  assign start_ref = !busy && init_done && ref_pend;  // refresh beats a request
  assign start_acc = !busy && init_done && !ref_pend && mem.req;

  // --------------------------------------------------
  // command sequencer, outputs set one step ahead
  always_ff @(posedge clk125_mhz) begin
    if (rst) begin
      sd_cmd  <= sdram_pkg::cmd_inhibit;
      busy    <= 1'b0;
      is_ref  <= 1'b0;
      is_wr   <= 1'b0;
      step    <= '0;
      data_oe <= 1'b0;
      sd_dqm  <= 2'b11;
      mem.ack <= 1'b0;
    end else begin
      sd_cmd  <= busy ? sdram_pkg::cmd_nop : sdram_pkg::cmd_inhibit;
      mem.ack <= 1'b0;
      if (init_cnt == sdram_pkg::init_cycles - 5) sd_cmd <= sdram_pkg::cmd_precharge;
      if (init_cnt == sdram_pkg::init_cycles - 15) sd_cmd <= sdram_pkg::cmd_load_mode;

      if (start_ref) begin
        sd_cmd <= sdram_pkg::cmd_auto_refresh;
        busy   <= 1'b1;
        is_ref <= 1'b1;
        step   <= '0;
      end else if (start_acc) begin
        sd_cmd <= sdram_pkg::cmd_active;  // RAS phase
        busy   <= 1'b1;
        is_ref <= 1'b0;
        is_wr  <= mem.we;
        step   <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (is_ref) begin
          if (step == sdram_pkg::step_ref_end) busy <= 1'b0;
        end else begin
          if (step == sdram_pkg::t_rcd - 1) begin  // CAS phase next
            sd_cmd  <= is_wr ? sdram_pkg::cmd_write : sdram_pkg::cmd_read;
            data_oe <= is_wr;
            sd_dqm  <= is_wr ? ~mem.be[1:0] : 2'b00;  // low half first
          end
          if (is_wr && step == sdram_pkg::t_rcd) begin
            sd_dqm  <= ~mem.be[3:2];
            mem.ack <= 1'b1;                      // ack with 2nd beat
          end
          if (is_wr && step == sdram_pkg::t_rcd + 1) begin
            data_oe <= 1'b0;  // bus back to hi-z
            sd_dqm  <= 2'b11;
          end
          if (!is_wr && step == sdram_pkg::step_rd_last) begin
            mem.ack <= 1'b1;
            sd_dqm  <= 2'b11;
          end
          if (step == sdram_pkg::step_acc_end) busy <= 1'b0;
        end
      end
    end
  end

  // address, write beats, read capture
  always_ff @(posedge clk125_mhz) begin
    if (init_cnt == sdram_pkg::init_cycles - 5) begin
      addr_q.col <= '{unused: '0, a10: 1'b1, col: '0};  // precharge all
      sd_ba      <= '0;
    end
    if (init_cnt == sdram_pkg::init_cycles - 15) addr_q.mode <= sdram_pkg::mode_word;
    if (start_acc) begin
      addr_q <= mem.addr[sdram_pkg::col_w-1 +: sdram_pkg::row_w];  // row
      sd_ba  <= mem.addr[sdram_pkg::col_w-1+sdram_pkg::row_w +: sdram_pkg::bank_w];
    end
    if (busy && !is_ref) begin
      if (step == sdram_pkg::t_rcd - 1) begin
        addr_q.col <= '{unused: '0, a10: 1'b1,
                        col: {1'b0, mem.addr[sdram_pkg::col_w-2:0], 1'b0}};
        dout_q     <= mem.wdata[15:0];
      end
      if (step == sdram_pkg::t_rcd) dout_q <= mem.wdata[31:16];
      if (step == sdram_pkg::step_rd_first) mem.rdata[15:0]  <= sd_data;
      if (step == sdram_pkg::step_rd_last)  mem.rdata[31:16] <= sd_data;
    end
  end

  // --------------------------------------------------
  a_no_early_active: assert property (@(posedge clk125_mhz) disable iff (rst)
    sd_cmd == sdram_pkg::cmd_active |-> $past(init_done));
  a_bus_free_on_read: assert property (@(posedge clk125_mhz) disable iff (rst)
    sd_cmd == sdram_pkg::cmd_read |->
      ##(sdram_pkg::cas_latency) !data_oe [*(sdram_pkg::burst_len + 1)]);

endmodule

`default_nettype wire

// File: hw/sdram_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_subsys (
  input  wire        clk125_mhz,
  input  wire        rst,
  // AXI4-Lite port 0
  input  wire        s0_awvalid, s0_wvalid, s0_bready, s0_arvalid, s0_rready,
  input  wire [24:0] s0_awaddr, s0_araddr,
  input  wire [31:0] s0_wdata,
  input  wire [3:0]  s0_wstrb,
  output wire        s0_awready, s0_wready, s0_bvalid, s0_arready, s0_rvalid,
  output wire [1:0]  s0_bresp, s0_rresp,
  output wire [31:0] s0_rdata,
  // AXI4-Lite port 1
  input  wire        s1_awvalid, s1_wvalid, s1_bready, s1_arvalid, s1_rready,
  input  wire [24:0] s1_awaddr, s1_araddr,
  input  wire [31:0] s1_wdata,
  input  wire [3:0]  s1_wstrb,
  output wire        s1_awready, s1_wready, s1_bvalid, s1_arready, s1_rvalid,
  output wire [1:0]  s1_bresp, s1_rresp,
  output wire [31:0] s1_rdata,
  // SDRAM pins
  inout  wire [15:0] sd_data,
  output wire [12:0] sd_addr,
  output wire [1:0]  sd_ba, sd_dqm,
  output wire        sd_cs, sd_ras, sd_cas, sd_we, sd_cke, sd_clk
);

  mem_req_if p0_if ();
  mem_req_if p1_if ();
  mem_req_if ctrl_if ();  // arbiter -> controller

  axil_port u_port0 (
    .clk125_mhz, .rst,
    .awvalid(s0_awvalid), .awready(s0_awready), .awaddr(s0_awaddr),
    .wvalid(s0_wvalid), .wready(s0_wready), .wdata(s0_wdata), .wstrb(s0_wstrb),
    .bvalid(s0_bvalid), .bready(s0_bready), .bresp(s0_bresp),
    .arvalid(s0_arvalid), .arready(s0_arready), .araddr(s0_araddr),
    .rvalid(s0_rvalid), .rready(s0_rready), .rdata(s0_rdata), .rresp(s0_rresp),
    .mem(p0_if.requester)
  );

  axil_port u_port1 (
    .clk125_mhz, .rst,
    .awvalid(s1_awvalid), .awready(s1_awready), .awaddr(s1_awaddr),
    .wvalid(s1_wvalid), .wready(s1_wready), .wdata(s1_wdata), .wstrb(s1_wstrb),
    .bvalid(s1_bvalid), .bready(s1_bready), .bresp(s1_bresp),
    .arvalid(s1_arvalid), .arready(s1_arready), .araddr(s1_araddr),
    .rvalid(s1_rvalid), .rready(s1_rready), .rdata(s1_rdata), .rresp(s1_rresp),
    .mem(p1_if.requester)
  );

  sdram_arbiter u_arb (
    .clk125_mhz, .rst,
    .p0(p0_if.server), .p1(p1_if.server), .mem(ctrl_if.requester)
  );

  sdram_ctrl u_ctrl (
    .clk125_mhz, .rst,
    .mem(ctrl_if.server),
    .sd_data, .sd_addr, .sd_ba, .sd_dqm,
    .sd_cs, .sd_ras, .sd_cas, .sd_we, .sd_cke, .sd_clk
  );

endmodule

`default_nettype wire

// File: dv/clk_rst_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_rst_gen (
  output logic clk125_mhz,
  output logic rst
);

  initial begin
    clk125_mhz = 1'b0;
    forever #4 clk125_mhz = ~clk125_mhz;  // 8 ns period
  end

  // high over two rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk125_mhz);
    @(negedge clk125_mhz);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/sdram_chip_model.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_chip_model (
  input  wire        sd_clk,
  input  wire        sd_cke,
  input  wire        sd_cs,
  input  wire        sd_ras,
  input  wire        sd_cas,
  input  wire        sd_we,
  input  wire [1:0]  sd_ba,
  input  wire [12:0] sd_addr,
  input  wire [1:0]  sd_dqm,
  inout  wire [15:0] sd_data
);

  logic [15:0] mem [logic [23:0]];  // {bank, row, col}, sparse
  logic [12:0] open_row [4];
  logic [15:0] dq_out;
  logic        dq_oe = 1'b0;
  logic [23:0] rd_key;
  logic [23:0] wr_key;
  logic        wr_next = 1'b0;      // second write beat due
  int          rd_cnt = 0;          // edges left in the read pipe

  assign sd_data = dq_oe ? dq_out : 16'hzzzz;

  // unwritten locations read as zero
  function automatic logic [15:0] fetch(input logic [23:0] key);
    return mem.exists(key) ? mem[key] : 16'h0000;
  endfunction

  task automatic store(input logic [23:0] key, input logic [15:0] d, input logic [1:0] dqm);
    logic [15:0] w;
    w = fetch(key);
    if (!dqm[0]) w[7:0] = d[7:0];    // dqm high masks the byte
    if (!dqm[1]) w[15:8] = d[15:8];
    mem[key] = w;
  endtask

  always @(posedge sd_clk) begin
    if (wr_next) begin
      store(wr_key, sd_data, sd_dqm);
      wr_next = 1'b0;
    end
    // CL3 read burst, beats on the 3rd and 4th edge after READ
    if (rd_cnt > 0) begin
      rd_cnt = rd_cnt - 1;
      if (rd_cnt == 2) begin
        dq_out <= fetch(rd_key);
        dq_oe  <= 1'b1;
      end
      if (rd_cnt == 1) dq_out <= fetch(rd_key + 1'b1);
      if (rd_cnt == 0) dq_oe <= 1'b0;  // release the bus
    end
    if (sd_cke && !sd_cs) begin
      case ({sd_ras, sd_cas, sd_we})
        3'b011: open_row[sd_ba] = sd_addr;  // ACTIVE
        3'b101: begin                        // READ
          rd_key = {sd_ba, open_row[sd_ba], sd_addr[8:0]};
          rd_cnt = 5;
        end
        3'b100: begin                        // WRITE, first beat now
          wr_key = {sd_ba, open_row[sd_ba], sd_addr[8:0]};
          store(wr_key, sd_data, sd_dqm);
          wr_key  = wr_key + 1'b1;
          wr_next = 1'b1;
        end
        default: ;  // precharge, refresh, mode: no data effect
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_sdram_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_subsys;

  localparam int n_txn      = 150;
  localparam int wait_limit = 300;   // cycles per wait
  localparam int ref_period = 960;
  localparam int min_ref_gap = 9;    // tRC
  // {cs, ras, cas, we}
  localparam logic [3:0] c_inhibit   = 4'b1111;
  localparam logic [3:0] c_nop       = 4'b0111;
  localparam logic [3:0] c_precharge = 4'b0010;
  localparam logic [3:0] c_refresh   = 4'b0001;
  localparam logic [3:0] c_load_mode = 4'b0000;

  wire clk125_mhz;
  wire rst;
  logic [1:0]        awvalid, wvalid, bready, arvalid, rready;
  logic [1:0][24:0]  awaddr, araddr;
  logic [1:0][31:0]  wdata;
  logic [1:0][3:0]   wstrb;
  wire  [1:0]        awready, wready, bvalid, arready, rvalid;
  wire  [1:0][1:0]   bresp, rresp;
  wire  [1:0][31:0]  rdata;
  wire  [15:0]       sd_data;
  wire  [12:0]       sd_addr;
  wire  [1:0]        sd_ba, sd_dqm;
  wire               sd_cs, sd_ras, sd_cas, sd_we, sd_cke, sd_clk;

  logic [31:0] lfsr;
  logic [31:0] ref_mem [logic [22:0]];  // reference model, word addressed
  logic [22:0] pool [2][64];            // per-port address set
  logic        t_rd [2][n_txn];
  logic [5:0]  t_idx [2][n_txn];
  logic [31:0] t_data [2][n_txn];
  logic [3:0]  t_strb [2][n_txn];
  logic [1:0]  t_delay [2][n_txn];
  int n_sent [2] = '{0, 0};
  int n_resp [2] = '{0, 0};
  int data_errs = 0;
  int proto_errs = 0;
  int cmd_errs = 0;
  int timeout_errs = 0;

  clk_rst_gen u_clk_rst (.clk125_mhz, .rst);

  sdram_subsys u_sdram_subsys (
    .clk125_mhz, .rst,
    .s0_awvalid(awvalid[0]), .s0_wvalid(wvalid[0]), .s0_bready(bready[0]),
    .s0_arvalid(arvalid[0]), .s0_rready(rready[0]),
    .s0_awaddr(awaddr[0]), .s0_araddr(araddr[0]), .s0_wdata(wdata[0]), .s0_wstrb(wstrb[0]),
    .s0_awready(awready[0]), .s0_wready(wready[0]), .s0_bvalid(bvalid[0]),
    .s0_arready(arready[0]), .s0_rvalid(rvalid[0]),
    .s0_bresp(bresp[0]), .s0_rresp(rresp[0]), .s0_rdata(rdata[0]),
    .s1_awvalid(awvalid[1]), .s1_wvalid(wvalid[1]), .s1_bready(bready[1]),
    .s1_arvalid(arvalid[1]), .s1_rready(rready[1]),
    .s1_awaddr(awaddr[1]), .s1_araddr(araddr[1]), .s1_wdata(wdata[1]), .s1_wstrb(wstrb[1]),
    .s1_awready(awready[1]), .s1_wready(wready[1]), .s1_bvalid(bvalid[1]),
    .s1_arready(arready[1]), .s1_rvalid(rvalid[1]),
    .s1_bresp(bresp[1]), .s1_rresp(rresp[1]), .s1_rdata(rdata[1]),
    .sd_data, .sd_addr, .sd_ba, .sd_dqm,
    .sd_cs, .sd_ras, .sd_cas, .sd_we, .sd_cke, .sd_clk
  );

  sdram_chip_model u_chip (
    .sd_clk, .sd_cke, .sd_cs, .sd_ras, .sd_cas, .sd_we,
    .sd_ba, .sd_addr, .sd_dqm, .sd_data
  );

  // --------------------------------------------------
  // random source, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] model_read(input logic [22:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : 32'h0;
  endfunction

  task automatic model_write(input logic [22:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] w;
    w = model_read(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) w[8*b +: 8] = d[8*b +: 8];  // strobed bytes only
    end
    ref_mem[a] = w;
  endtask

  // --------------------------------------------------
  // one AXI4-Lite transaction, entered and left on a falling edge
  task automatic do_txn(input int p, input bit is_rd, input logic [22:0] waddr,
                        input logic [31:0] data, input logic [3:0] strb, input int delay);
    int n;
    logic [31:0] exp;
    logic [31:0] held;
    n_sent[p]++;
    if (is_rd) begin
      arvalid[p] = 1'b1;
      araddr[p]  = {waddr, 2'b00};
    end else begin
      awvalid[p] = 1'b1;
      wvalid[p]  = 1'b1;
      awaddr[p]  = {waddr, 2'b00};
      wdata[p]   = data;
      wstrb[p]   = strb;
    end
    n = 0;
    do begin
      @(negedge clk125_mhz);
      n++;
    end while (!(is_rd ? arready[p] : (awready[p] && wready[p])) && n < wait_limit);
    if (!(is_rd ? arready[p] : (awready[p] && wready[p]))) begin
      timeout_errs++;
      $display("port %0d: address handshake never came for word %h", p, waddr);
      return;
    end
    arvalid[p] = 1'b0;
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    n = 0;
    while (!(is_rd ? rvalid[p] : bvalid[p]) && n < wait_limit) begin
      @(negedge clk125_mhz);
      n++;
    end
    if (!(is_rd ? rvalid[p] : bvalid[p])) begin
      timeout_errs++;
      $display("port %0d: no response arrived for word %h", p, waddr);
      return;
    end
    n_resp[p]++;
    assert ((is_rd ? rresp[p] : bresp[p]) == 2'b00) else begin
      data_errs++;
      $display("ERROR port %0d %s: expected 0, received %h",
               p, is_rd ? "rresp" : "bresp", is_rd ? rresp[p] : bresp[p]);
    end
    exp = model_read(waddr);
    if (is_rd) begin
      assert (rdata[p] == exp) else begin
        data_errs++;
        $display("ERROR port %0d rdata @%h: expected %h, received %h", p, waddr, exp, rdata[p]);
      end
    end
    // hold the ready low, probe with new valids meanwhile
    held = rdata[p];
    for (int i = 0; i < delay; i++) begin
      arvalid[p] = 1'b1;
      awvalid[p] = 1'b1;
      wvalid[p]  = 1'b1;
      @(negedge clk125_mhz);
      assert (is_rd ? rvalid[p] : bvalid[p]) else begin
        proto_errs++;
        $display("port %0d: response valid dropped while ready was low", p);
      end
      assert (rdata[p] === held) else begin
        data_errs++;
        $display("ERROR port %0d rdata under back-pressure: expected %h, received %h",
                 p, held, rdata[p]);
      end
      assert (!arready[p] && !awready[p]) else begin
        proto_errs++;
        $display("port %0d: new transaction accepted before the response was taken", p);
      end
    end
    arvalid[p] = 1'b0;
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    if (is_rd) rready[p] = 1'b1;
    else bready[p] = 1'b1;
    @(negedge clk125_mhz);  // handshake done on the rising edge
    rready[p] = 1'b0;
    bready[p] = 1'b0;
    assert (!rvalid[p] && !bvalid[p]) else begin
      proto_errs++;
      $display("port %0d: response still valid after the handshake", p);
    end
    if (!is_rd) model_write(waddr, data, strb);
  endtask

  task automatic run_port(input int p);
    for (int i = 0; i < n_txn; i++) begin
      do_txn(p, t_rd[p][i], pool[p][t_idx[p][i]], t_data[p][i], t_strb[p][i], t_delay[p][i]);
    end
  endtask

  // --------------------------------------------------
  // pin command monitor, mid-cycle sampling
  logic [3:0] pin_cmd;
  sdram_pkg::sd_addr_u mode_dec;
  int cyc = 0;
  int n_cmds = 0;
  int n_refresh = 0;
  int init_cyc = 0;
  int last_ref = 0;

  assign pin_cmd = {sd_cs, sd_ras, sd_cas, sd_we};

  always @(negedge clk125_mhz) begin
    if (rst === 1'b0) begin
      cyc++;
      if (pin_cmd != c_inhibit && pin_cmd != c_nop) begin
        if (n_cmds == 0) begin
          assert (pin_cmd == c_precharge && sd_addr[10]) else begin
            cmd_errs++;
            $display("ERROR pin_cmd first: expected %h with A10, received %h sd_addr %h",
                     c_precharge, pin_cmd, sd_addr);
          end
        end else if (n_cmds == 1) begin
          mode_dec = sd_addr;
          init_cyc = cyc;
          assert (pin_cmd == c_load_mode) else begin
            cmd_errs++;
            $display("ERROR pin_cmd second: expected %h, received %h", c_load_mode, pin_cmd);
          end
          // BL2, sequential, CL3
          assert (mode_dec.mode.burst_len == 3'b001 && mode_dec.mode.burst_type == 1'b0 &&
                  mode_dec.mode.cas_lat == 3'd3) else begin
            cmd_errs++;
            $display("ERROR sd_addr mode word: received %h", sd_addr);
          end
        end
        n_cmds++;
        if (pin_cmd == c_refresh) begin
          if (n_refresh > 0) begin
            assert (cyc - last_ref >= min_ref_gap) else begin
              cmd_errs++;
              $display("refreshes only %0d cycles apart", cyc - last_ref);
            end
          end
          n_refresh++;
          last_ref = cyc;
        end
      end
    end
  end

  // --------------------------------------------------
  initial begin
    int n;
    logic [31:0] r;
    awvalid = '0;
    wvalid  = '0;
    bready  = '0;
    arvalid = '0;
    rready  = '0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    lfsr    = 32'h55ce54e1;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(posedge clk125_mhz);
      n++;
    end
    if (rst !== 1'b0) begin
      timeout_errs++;
      $display("reset was never released");
    end
    @(negedge clk125_mhz);
    assert (awready == 0 && wready == 0 && arready == 0 && bvalid == 0 && rvalid == 0)
      else begin
        proto_errs++;
        $display("ERROR after reset: awready %h wready %h arready %h bvalid %h rvalid %h",
                 awready, wready, arready, bvalid, rvalid);
      end
    assert (pin_cmd == c_inhibit && sd_dqm == 2'b11 && sd_data === 16'hzzzz) else begin
      cmd_errs++;
      $display("ERROR pins after reset: pin_cmd %h sd_dqm %h sd_data %h",
               pin_cmd, sd_dqm, sd_data);
    end

    // directed port 0: full words, unwritten word, byte merge
    do_txn(0, 1'b0, 23'h000123, 32'h1234_5678, 4'hf, 0);
    do_txn(0, 1'b0, 23'h3a5c41, 32'hcafe_f00d, 4'hf, 2);
    // same row and column in the other three banks
    do_txn(0, 1'b0, 23'h200123, 32'h2222_2222, 4'hf, 0);
    do_txn(1, 1'b0, 23'h400123, 32'h4444_4444, 4'hf, 0);
    do_txn(1, 1'b0, 23'h600123, 32'h6666_6666, 4'hf, 0);
    do_txn(1, 1'b1, 23'h400123, 32'h0, 4'h0, 0);
    do_txn(1, 1'b1, 23'h600123, 32'h0, 4'h0, 0);
    do_txn(0, 1'b1, 23'h200123, 32'h0, 4'h0, 0);
    do_txn(0, 1'b1, 23'h000123, 32'h0, 4'h0, 1);
    do_txn(0, 1'b1, 23'h3a5c41, 32'h0, 4'h0, 0);
    do_txn(0, 1'b1, 23'h077777, 32'h0, 4'h0, 3);  // never written
    do_txn(0, 1'b0, 23'h000123, 32'haabb_ccdd, 4'b0101, 0);
    do_txn(0, 1'b1, 23'h000123, 32'h0, 4'h0, 2);

    // random traffic, port 1 owns the upper half
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 64; k++) begin
        draw(22, r);
        pool[p][k] = {(p == 1), r[21:0]};
      end
      for (int i = 0; i < n_txn; i++) begin
        draw(1, r);
        t_rd[p][i] = r[0];
        draw(6, r);
        t_idx[p][i] = r[5:0];
        draw(32, r);
        t_data[p][i] = r;
        draw(4, r);
        t_strb[p][i] = r[3:0];
        draw(2, r);
        t_delay[p][i] = r[1:0];
      end
    end
    fork
      run_port(0);
      run_port(1);
    join
    repeat (4) @(negedge clk125_mhz);

    for (int p = 0; p < 2; p++) begin
      assert (n_resp[p] == n_sent[p]) else begin
        proto_errs++;
        $display("port %0d: %0d transactions but %0d responses", p, n_sent[p], n_resp[p]);
      end
    end
    assert (n_refresh >= (cyc - init_cyc) / (ref_period + 20)) else begin
      cmd_errs++;
      $display("only %0d refreshes in %0d cycles", n_refresh, cyc - init_cyc);
    end
    $display("errors: data %0d, protocol %0d, command %0d, timeout %0d (refreshes %0d)",
             data_errs, proto_errs, cmd_errs, timeout_errs, n_refresh);
    if (data_errs + proto_errs + cmd_errs + timeout_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hw/sdram_pkg.sv
hw/mem_req_if.sv
hw/axil_port.sv
hw/sdram_arbiter.sv
hw/sdram_ctrl.sv
hw/sdram_subsys.sv
dv/clk_rst_gen.sv
dv/sdram_chip_model.sv
dv/tb_sdram_subsys.sv

// File: Bender.yml
package:
  name: sdram_subsys

sources:
  - hw/sdram_pkg.sv
  - hw/mem_req_if.sv
  - hw/axil_port.sv
  - hw/sdram_arbiter.sv
  - hw/sdram_ctrl.sv
  - hw/sdram_subsys.sv
  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/sdram_chip_model.sv
      - dv/tb_sdram_subsys.sv
